//--- gfp_dispatcher.f
hdl/gfp_block_pkg.sv
hdl/ddr_read_pkg.sv
hdl/block_wr_if.sv
hdl/block_fetch_ctrl.sv
hdl/block_buffer.sv
hdl/exp_unpacker.sv
hdl/gfp_dispatcher.sv
sim/tb_clock_gen.sv
sim/gfp_dispatcher_assert.sv
sim/gfp_dispatcher_tb.sv

//--- hdl/block_buffer.sv
`timescale 1ns/1ps
// ==============================
// Line store for both targets; packed exponents read combinationally,
// mantissas through two registered ports for the compute engine
// ==============================
module block_buffer (
    input  logic                    i_clk,
    // Fetched lines
    block_wr_if.buffer              wr,
    // Packed exponent lines for the unpacker
    input  gfp_block_pkg::target_e  i_exp_target,
    input  logic [3:0]              i_exp_line_addr,
    output gfp_block_pkg::line_t    o_exp_line_data,
    // Left mantissa read port
    input  logic                    i_man_rd_en_left,
    input  gfp_block_pkg::man_idx_t i_man_rd_addr_left,
    output gfp_block_pkg::line_t    o_man_rd_data_left,
    // Right mantissa read port
    input  logic                    i_man_rd_en_right,
    input  gfp_block_pkg::man_idx_t i_man_rd_addr_right,
    output gfp_block_pkg::line_t    o_man_rd_data_right
);
    import gfp_block_pkg::*;

    // 528 lines per target
    line_t line_mem [2][BLOCK_LINES];

    // Mantissa m sits behind the packed exponent lines
    function automatic line_idx_t man_line(input man_idx_t idx);
        man_line = line_idx_t'(EXP_LINES) + line_idx_t'(idx);
    endfunction

    // Write port
    always_ff @(posedge i_clk) begin
        if (wr.wr_en) begin
            line_mem[wr.wr_target][wr.wr_line] <= wr.wr_data;
        end
    end

    // Packed exponent read, same cycle
    assign o_exp_line_data = line_mem[i_exp_target][line_idx_t'(i_exp_line_addr)];

    // ==============================
    // Mantissa read ports, one cycle latency
    // ==============================
    always_ff @(posedge i_clk) begin
        if (i_man_rd_en_left) begin
            o_man_rd_data_left <= line_mem[TGT_LEFT][man_line(i_man_rd_addr_left)];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_man_rd_en_right) begin
            o_man_rd_data_right <= line_mem[TGT_RIGHT][man_line(i_man_rd_addr_right)];
        end
    end

    // Both ports read in parallel, never contend with the write port

endmodule

//--- hdl/block_fetch_ctrl.sv
`timescale 1ns/1ps
// ==============================
// Fetch controller: reads one GFP8 block from DDR in 16-beat bursts
// and writes each returned line into the block buffer
// ==============================
module block_fetch_ctrl #(
    parameter logic [8:0] PAGE_ID = 9'd2
) (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    // Fetch command, rising edge starts a block read
    input  logic                    i_fetch_en,
    input  ddr_read_pkg::ddr_line_t i_fetch_addr,
    input  gfp_block_pkg::target_e  i_fetch_target,
    output logic                    o_fetch_done,
    // DDR read address channel
    output logic                    o_ddr_arvalid,
    output ddr_read_pkg::ddr_addr_t o_ddr_araddr,
    input  logic                    i_ddr_arready,
    // DDR read data channel
    input  logic                    i_ddr_rvalid,
    input  gfp_block_pkg::line_t    i_ddr_rdata,
    input  logic                    i_ddr_rlast,
    output logic                    o_ddr_rready,
    // Line writes into the buffer
    block_wr_if.producer            wr,
    // Status for the exponent unpacker
    output gfp_block_pkg::target_e  o_target,
    output logic                    o_man_phase
);
    import gfp_block_pkg::*;
    import ddr_read_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;
    logic         fetch_en_q;
    logic         fetch_start;
    ddr_line_t    base_line;
    ddr_line_t    burst_line;
    target_e      target_q;
    logic [4:0]   exp_cnt;
    logic [9:0]   man_cnt;
    logic         ar_take;
    logic         r_take;
    logic         man_last;
    logic         done_q;

    // Command edges outside idle are dropped
    assign fetch_start = i_fetch_en && !fetch_en_q && (state == FS_IDLE);
    assign ar_take     = o_ddr_arvalid && i_ddr_arready;
    assign r_take      = i_ddr_rvalid && o_ddr_rready;
    // Beat that completes the 512th mantissa line
    assign man_last    = (state == FS_MAN) && (man_cnt == 10'(MAN_LINES - 1));

    // ==============================
    // Fetch FSM
    // ==============================
    always_comb begin
        state_next = state;
        case (state)
            FS_IDLE: begin
                if (fetch_start) begin
                    state_next = FS_ADDR;
                end
            end
            FS_ADDR: begin
                // Exponent bursts come first
                if (ar_take) begin
                    state_next = (exp_cnt < 5'(EXP_LINES)) ? FS_EXP : FS_MAN;
                end
            end
            FS_EXP: begin
                if (r_take && i_ddr_rlast) begin
                    state_next = FS_ADDR;
                end
            end
            FS_MAN: begin
                if (r_take && i_ddr_rlast) begin
                    state_next = man_last ? FS_DONE : FS_ADDR;
                end
            end
            FS_DONE: begin
                state_next = FS_IDLE;
            end
            default: begin
                state_next = FS_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state      <= FS_IDLE;
            fetch_en_q <= 1'b0;
            done_q     <= 1'b0;
            exp_cnt    <= '0;
            man_cnt    <= '0;
            burst_line <= '0;
        end else begin
            state      <= state_next;
            fetch_en_q <= i_fetch_en;
            // One-cycle pulse on the clock after FS_DONE
            done_q     <= (state == FS_DONE);
            if (fetch_start) begin
                exp_cnt    <= '0;
                man_cnt    <= '0;
                burst_line <= '0;
            end
            // Next burst starts 16 lines further on
            if (ar_take) begin
                burst_line <= burst_line + ddr_line_t'(BURST_BEATS);
            end
            if (r_take && (state == FS_EXP)) begin
                exp_cnt <= exp_cnt + 5'd1;
            end
            if (r_take && (state == FS_MAN)) begin
                man_cnt <= man_cnt + 10'd1;
            end
        end
    end

    // Command capture
    always_ff @(posedge i_clk) begin
        if (fetch_start) begin
            base_line <= i_fetch_addr;
            target_q  <= i_fetch_target;
        end
    end

    // ==============================
    // Buffer writes, one cycle after each taken beat
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr.wr_en <= 1'b0;
        end else begin
            wr.wr_en <= r_take;
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_take) begin
            wr.wr_target <= target_q;
            wr.wr_data   <= i_ddr_rdata;
            // Exponents at 0..15, mantissas at 16..527
            if (state == FS_EXP) begin
                wr.wr_line <= line_idx_t'(exp_cnt);
            end else begin
                wr.wr_line <= line_idx_t'(EXP_LINES) + man_cnt;
            end
        end
    end

    assign o_ddr_arvalid = (state == FS_ADDR);
    assign o_ddr_rready  = (state == FS_EXP) || (state == FS_MAN);
    assign o_ddr_araddr  = {PAGE_ID, 2'b00, base_line + burst_line, {BYTE_SHIFT{1'b0}}};
    assign o_fetch_done  = done_q;
    assign o_target      = target_q;
    // Mantissa phase also covers the address cycles between its bursts
    assign o_man_phase   = (state == FS_MAN) || ((state == FS_ADDR) && (man_cnt != '0));

endmodule

//--- hdl/block_wr_if.sv
`timescale 1ns/1ps
// ==============================
// Line write path from the fetch controller into the block buffer
// ==============================
interface block_wr_if;
    import gfp_block_pkg::*;

    // One line per cycle while wr_en is high, no back-pressure
    logic      wr_en;
    target_e   wr_target;
    line_idx_t wr_line;
    line_t     wr_data;

    // Fetch controller side
    modport producer (
        output wr_en,
        output wr_target,
        output wr_line,
        output wr_data
    );

    // Block buffer side
    modport buffer (
        input wr_en,
        input wr_target,
        input wr_line,
        input wr_data
    );

endinterface

//--- hdl/ddr_read_pkg.sv
// ==============================
// DDR read side: address format, burst size and fetch FSM states
// ==============================
package ddr_read_pkg;

    // {page[8:0], pad[1:0], line[25:0], byte[4:0]}
    localparam int DDR_ADDR_W  = 42;
    localparam int DDR_LINE_W  = 26;
    localparam int BYTE_SHIFT  = 5;
    // Fixed INCR burst, memory side knows the length
    localparam int BURST_BEATS = 16;

    typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;
    typedef logic [DDR_LINE_W-1:0] ddr_line_t;

    typedef enum logic [2:0] {
        FS_IDLE = 3'd0,
        FS_ADDR = 3'd1,
        FS_EXP  = 3'd2,
        FS_MAN  = 3'd3,
        FS_DONE = 3'd4
    } fetch_state_e;

endpackage

//--- hdl/exp_unpacker.sv
`timescale 1ns/1ps
// ==============================
// Unpacks 512 exponent bytes into the aligned store of the fetched
// target while mantissas stream in; serves both stores combinationally
// ==============================
module exp_unpacker (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_man_phase,
    input  gfp_block_pkg::target_e  i_target,
    // Packed exponent line lookup
    output logic [3:0]              o_exp_line_addr,
    input  gfp_block_pkg::line_t    i_exp_line_data,
    // Aligned exponent reads for the compute engine
    input  gfp_block_pkg::exp_idx_t i_exp_rd_addr_left,
    output gfp_block_pkg::exp_t     o_exp_rd_data_left,
    input  gfp_block_pkg::exp_idx_t i_exp_rd_addr_right,
    output gfp_block_pkg::exp_t     o_exp_rd_data_right
);
    import gfp_block_pkg::*;

    localparam int EXP_COUNT  = EXP_LINES * EXPS_PER_LINE;
    localparam int BYTE_SEL_W = $clog2(EXPS_PER_LINE);

    logic     man_phase_q;
    logic     unpack_start;
    logic     unpack_busy;
    exp_idx_t unpack_idx;
    target_e  unpack_tgt;
    exp_t     exp_byte;

    // Aligned stores, one per target
    exp_t exp_store [2][EXP_COUNT];

    assign unpack_start = i_man_phase && !man_phase_q;

    // Line n/32 and byte n%32 of the current index
    assign o_exp_line_addr = unpack_idx[$bits(exp_idx_t)-1:BYTE_SEL_W];
    assign exp_byte = i_exp_line_data[{unpack_idx[BYTE_SEL_W-1:0], 3'b000} +: 8];

    // ==============================
    // Unpack counter, free running once started
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            man_phase_q <= 1'b0;
            unpack_busy <= 1'b0;
            unpack_idx  <= '0;
        end else begin
            man_phase_q <= i_man_phase;
            if (unpack_start) begin
                unpack_busy <= 1'b1;
                unpack_idx  <= '0;
            end else if (unpack_busy) begin
                unpack_idx <= unpack_idx + 1'b1;
                // Last of 512 writes
                if (unpack_idx == exp_idx_t'(EXP_COUNT - 1)) begin
                    unpack_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (unpack_start) begin
            unpack_tgt <= i_target;
        end
    end

    // One exponent per cycle into the captured target
    always_ff @(posedge i_clk) begin
        if (unpack_busy) begin
            exp_store[unpack_tgt][unpack_idx] <= exp_byte;
        end
    end

    assign o_exp_rd_data_left  = exp_store[TGT_LEFT][i_exp_rd_addr_left];
    assign o_exp_rd_data_right = exp_store[TGT_RIGHT][i_exp_rd_addr_right];

endmodule

//--- hdl/gfp_block_pkg.sv
// ==============================
// GFP8 block layout and line data types shared by the buffer,
// the exponent unpacker and the testbench
// ==============================
package gfp_block_pkg;

    // Line and bus beat width
    localparam int DATA_W = 256;

    // Block layout: packed exponent lines first, then mantissa lines
    localparam int EXP_LINES     = 16;
    localparam int MAN_LINES     = 512;
    localparam int BLOCK_LINES   = EXP_LINES + MAN_LINES;
    localparam int EXPS_PER_LINE = DATA_W / 8;

    typedef logic [DATA_W-1:0] line_t;

    // Line index inside one block, 0 to 527
    typedef logic [$clog2(BLOCK_LINES)-1:0] line_idx_t;
    typedef logic [$clog2(MAN_LINES)-1:0]   man_idx_t;

    // One 8-bit shared exponent and its aligned index
    typedef logic [7:0] exp_t;
    typedef logic [$clog2(EXP_LINES * EXPS_PER_LINE)-1:0] exp_idx_t;

    // Which operand buffer a block lands in
    typedef enum logic {
        TGT_LEFT  = 1'b0,
        TGT_RIGHT = 1'b1
    } target_e;

endpackage

//--- hdl/gfp_dispatcher.sv
`timescale 1ns/1ps
// ==============================
// GFP8 block dispatcher top: DDR fetch, block buffer and exponent unpack
// ==============================
module gfp_dispatcher #(
    parameter logic [8:0] PAGE_ID = 9'd2
) (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    // Fetch command
    input  logic                    i_fetch_en,
    input  ddr_read_pkg::ddr_line_t i_fetch_addr,
    input  gfp_block_pkg::target_e  i_fetch_target,
    output logic                    o_fetch_done,
    // DDR read channels
    output logic                    o_ddr_arvalid,
    output ddr_read_pkg::ddr_addr_t o_ddr_araddr,
    input  logic                    i_ddr_arready,
    input  logic                    i_ddr_rvalid,
    input  gfp_block_pkg::line_t    i_ddr_rdata,
    input  logic                    i_ddr_rlast,
    output logic                    o_ddr_rready,
    // Mantissa reads
    input  logic                    i_man_rd_en_left,
    input  gfp_block_pkg::man_idx_t i_man_rd_addr_left,
    output gfp_block_pkg::line_t    o_man_rd_data_left,
    input  logic                    i_man_rd_en_right,
    input  gfp_block_pkg::man_idx_t i_man_rd_addr_right,
    output gfp_block_pkg::line_t    o_man_rd_data_right,
    // Aligned exponent reads
    input  gfp_block_pkg::exp_idx_t i_exp_rd_addr_left,
    output gfp_block_pkg::exp_t     o_exp_rd_data_left,
    input  gfp_block_pkg::exp_idx_t i_exp_rd_addr_right,
    output gfp_block_pkg::exp_t     o_exp_rd_data_right
);
    import gfp_block_pkg::*;

    target_e    fetch_target;
    logic       man_phase;
    logic [3:0] exp_line_addr;
    line_t      exp_line_data;

    block_wr_if u_block_wr_if ();

    block_fetch_ctrl #(
        .PAGE_ID (PAGE_ID)
    ) u_block_fetch_ctrl (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_en     (i_fetch_en),
        .i_fetch_addr   (i_fetch_addr),
        .i_fetch_target (i_fetch_target),
        .o_fetch_done   (o_fetch_done),
        .o_ddr_arvalid  (o_ddr_arvalid),
        .o_ddr_araddr   (o_ddr_araddr),
        .i_ddr_arready  (i_ddr_arready),
        .i_ddr_rvalid   (i_ddr_rvalid),
        .i_ddr_rdata    (i_ddr_rdata),
        .i_ddr_rlast    (i_ddr_rlast),
        .o_ddr_rready   (o_ddr_rready),
        .wr             (u_block_wr_if.producer),
        .o_target       (fetch_target),
        .o_man_phase    (man_phase)
    );

    block_buffer u_block_buffer (
        .i_clk               (i_clk),
        .wr                  (u_block_wr_if.buffer),
        .i_exp_target        (fetch_target),
        .i_exp_line_addr     (exp_line_addr),
        .o_exp_line_data     (exp_line_data),
        .i_man_rd_en_left    (i_man_rd_en_left),
        .i_man_rd_addr_left  (i_man_rd_addr_left),
        .o_man_rd_data_left  (o_man_rd_data_left),
        .i_man_rd_en_right   (i_man_rd_en_right),
        .i_man_rd_addr_right (i_man_rd_addr_right),
        .o_man_rd_data_right (o_man_rd_data_right)
    );

    exp_unpacker u_exp_unpacker (
        .i_clk               (i_clk),
        .i_reset_n           (i_reset_n),
        .i_man_phase         (man_phase),
        .i_target            (fetch_target),
        .o_exp_line_addr     (exp_line_addr),
        .i_exp_line_data     (exp_line_data),
        .i_exp_rd_addr_left  (i_exp_rd_addr_left),
        .o_exp_rd_data_left  (o_exp_rd_data_left),
        .i_exp_rd_addr_right (i_exp_rd_addr_right),
        .o_exp_rd_data_right (o_exp_rd_data_right)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the dispatcher testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f gfp_dispatcher.f \
    --top-module gfp_dispatcher_tb -o sim_gfp_dispatcher

# Keep running after an assertion error so the testbench reports the result
./obj_dir/sim_gfp_dispatcher +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- sim/gfp_dispatcher_assert.sv
`timescale 1ns/1ps
// ==============================
// Bound port checks for the quiet bus after reset, burst addresses
// and the done pulse
// ==============================
module gfp_dispatcher_assert (
    input logic                    i_clk,
    input logic                    i_reset_n,
    input logic                    i_fetch_en,
    input ddr_read_pkg::ddr_line_t i_fetch_addr,
    input logic                    o_fetch_done,
    input logic                    o_ddr_arvalid,
    input ddr_read_pkg::ddr_addr_t o_ddr_araddr,
    input logic                    i_ddr_arready,
    input logic                    i_ddr_rvalid,
    input logic                    o_ddr_rready
);
    import ddr_read_pkg::*;

    // Page routed by the testbench and beats in one block
    localparam logic [8:0] EXP_PAGE    = 9'd2;
    localparam int         BLOCK_BEATS = 528;

    // Failed checks counted for the testbench summary
    int unsigned fail_count = 0;

    logic        fetch_en_q;
    logic        cmd_seen;
    logic        busy;
    ddr_line_t   base_line;
    ddr_line_t   burst_line;
    int unsigned beat_cnt;
    ddr_addr_t   exp_addr;

    // Expected burst line and beat count of the accepted command
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            fetch_en_q <= 1'b0;
            cmd_seen   <= 1'b0;
            busy       <= 1'b0;
            base_line  <= '0;
            burst_line <= '0;
            beat_cnt   <= 0;
        end else begin
            fetch_en_q <= i_fetch_en;
            if (i_fetch_en) begin
                cmd_seen <= 1'b1;
            end
            // Edges while a block is in flight are not commands
            if (i_fetch_en && !fetch_en_q && !busy) begin
                busy       <= 1'b1;
                base_line  <= i_fetch_addr;
                burst_line <= '0;
                beat_cnt   <= 0;
            end else begin
                if (o_fetch_done) begin
                    busy <= 1'b0;
                end
                if (o_ddr_arvalid && i_ddr_arready) begin
                    burst_line <= burst_line + 26'd16;
                end
                if (i_ddr_rvalid && o_ddr_rready) begin
                    beat_cnt <= beat_cnt + 1;
                end
            end
        end
    end

    // Page, zero pad, base plus 16 per burst, zero byte bits
    assign exp_addr = {EXP_PAGE, 2'b00, base_line + burst_line, 5'b00000};

    // ==============================
    // Checks
    // ==============================
    a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !cmd_seen |-> !o_ddr_arvalid && !o_ddr_rready && !o_fetch_done)
    else begin
        $error("read bus or done active before the first command");
        fail_count++;
    end

    a_burst_addr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_ddr_arvalid |-> o_ddr_araddr == exp_addr)
    else begin
        $error("CHECK FAILED o_ddr_araddr: got %h expected %h",
               $sampled(o_ddr_araddr), $sampled(exp_addr));
        fail_count++;
    end

    a_addr_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_ddr_arvalid && !i_ddr_arready |=> o_ddr_arvalid && $stable(o_ddr_araddr))
    else begin
        $error("read address dropped or changed before it was taken");
        fail_count++;
    end

    // Done only closes a full block of an accepted command
    a_done_after_block: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_fetch_done |-> busy && beat_cnt == BLOCK_BEATS)
    else begin
        $error("done pulse without a complete block of %0d beats", BLOCK_BEATS);
        fail_count++;
    end

    a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_fetch_done |=> !o_fetch_done)
    else begin
        $error("done held for more than one cycle");
        fail_count++;
    end

endmodule

bind gfp_dispatcher gfp_dispatcher_assert u_gfp_dispatcher_assert (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_fetch_en    (i_fetch_en),
    .i_fetch_addr  (i_fetch_addr),
    .o_fetch_done  (o_fetch_done),
    .o_ddr_arvalid (o_ddr_arvalid),
    .o_ddr_araddr  (o_ddr_araddr),
    .i_ddr_arready (i_ddr_arready),
    .i_ddr_rvalid  (i_ddr_rvalid),
    .o_ddr_rready  (o_ddr_rready)
);

//--- sim/gfp_dispatcher_tb.sv
`timescale 1ns/1ps
// ==============================
// Dispatcher testbench: DDR read responder, three block fetches,
// read-back of mantissa lines and aligned exponents
// ==============================
module gfp_dispatcher_tb;
    import gfp_block_pkg::*;
    import ddr_read_pkg::*;

    // Three stalled fetches of about 1200 cycles plus six 512-entry read-backs
    localparam int          MAX_CYCLES = 8000;
    localparam int          EXP_COUNT  = EXP_LINES * EXPS_PER_LINE;
    localparam logic [31:0] LCG_SEED   = 32'h5e7e7ec1;

    logic clk;
    logic reset_n;

    // DUT inputs
    logic      fetch_en            = 1'b0;
    ddr_line_t fetch_addr          = '0;
    target_e   fetch_target        = TGT_LEFT;
    logic      ddr_arready         = 1'b0;
    logic      ddr_rvalid          = 1'b0;
    line_t     ddr_rdata           = '0;
    logic      ddr_rlast           = 1'b0;
    logic      man_rd_en_left      = 1'b0;
    man_idx_t  man_rd_addr_left    = '0;
    logic      man_rd_en_right     = 1'b0;
    man_idx_t  man_rd_addr_right   = '0;
    exp_idx_t  exp_rd_addr_left    = '0;
    exp_idx_t  exp_rd_addr_right   = '0;

    // DUT outputs
    logic      fetch_done;
    logic      ddr_arvalid;
    ddr_addr_t ddr_araddr;
    logic      ddr_rready;
    line_t     man_rd_data_left;
    line_t     man_rd_data_right;
    exp_t      exp_rd_data_left;
    exp_t      exp_rd_data_right;

    // Responder state
    ddr_line_t   burst_q [$];
    int          beat_idx    = 0;
    logic        stall_heavy = 1'b0;
    logic [31:0] rng_state   = LCG_SEED;

    int cycle_cnt    = 0;
    int done_cnt     = 0;
    int check_errs   = 0;
    int err_mark     = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (5)
    ) u_tb_clock_gen (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    gfp_dispatcher #(
        .PAGE_ID (9'd2)
    ) u_gfp_dispatcher (
        .i_clk               (clk),
        .i_reset_n           (reset_n),
        .i_fetch_en          (fetch_en),
        .i_fetch_addr        (fetch_addr),
        .i_fetch_target      (fetch_target),
        .o_fetch_done        (fetch_done),
        .o_ddr_arvalid       (ddr_arvalid),
        .o_ddr_araddr        (ddr_araddr),
        .i_ddr_arready       (ddr_arready),
        .i_ddr_rvalid        (ddr_rvalid),
        .i_ddr_rdata         (ddr_rdata),
        .i_ddr_rlast         (ddr_rlast),
        .o_ddr_rready        (ddr_rready),
        .i_man_rd_en_left    (man_rd_en_left),
        .i_man_rd_addr_left  (man_rd_addr_left),
        .o_man_rd_data_left  (man_rd_data_left),
        .i_man_rd_en_right   (man_rd_en_right),
        .i_man_rd_addr_right (man_rd_addr_right),
        .o_man_rd_data_right (man_rd_data_right),
        .i_exp_rd_addr_left  (exp_rd_addr_left),
        .o_exp_rd_data_left  (exp_rd_data_left),
        .i_exp_rd_addr_right (exp_rd_addr_right),
        .o_exp_rd_data_right (exp_rd_data_right)
    );

    // ==============================
    // Reference rules
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte k of absolute line A (base plus relative line) is the low byte of A + k
    function automatic line_t line_pattern(input ddr_line_t abs_line);
        line_t     data;
        ddr_line_t sum;
        for (int k = 0; k < EXPS_PER_LINE; k++) begin
            sum = abs_line + ddr_line_t'(k);
            data[k*8 +: 8] = sum[7:0];
        end
        return data;
    endfunction

    // Exponent n sits at byte n%32 of packed line n/32
    function automatic exp_t aligned_exp(input ddr_line_t base, input int n);
        ddr_line_t sum;
        sum = base + ddr_line_t'(n / EXPS_PER_LINE) + ddr_line_t'(n % EXPS_PER_LINE);
        return sum[7:0];
    endfunction

    function automatic int total_errors();
        return check_errs + int'(u_gfp_dispatcher.u_gfp_dispatcher_assert.fail_count);
    endfunction

    // ==============================
    // DDR read responder
    // ==============================
    always @(posedge clk) begin : ddr_responder
        logic [31:0] rnd;
        logic        gap;
        rnd       = lcg_next(rng_state);
        rng_state = rnd;
        gap       = stall_heavy ? rnd[29] : (rnd[29:27] == 3'd0);
        if (!reset_n) begin
            ddr_arready <= 1'b0;
            ddr_rvalid  <= 1'b0;
            ddr_rlast   <= 1'b0;
            beat_idx = 0;
            burst_q.delete();
        end else begin
            // Address taken at this edge queues one 16-beat burst
            if (ddr_arvalid && ddr_arready) begin
                burst_q.push_back(ddr_araddr[BYTE_SHIFT +: DDR_LINE_W]);
            end
            ddr_arready <= stall_heavy ? (rnd[31:30] == 2'd0) : (rnd[31:30] != 2'd0);
            // A beat that was not taken stays on the bus
            if (!(ddr_rvalid && !ddr_rready)) begin
                if (ddr_rvalid) begin
                    if (ddr_rlast) begin
                        void'(burst_q.pop_front());
                        beat_idx = 0;
                    end else begin
                        beat_idx = beat_idx + 1;
                    end
                end
                if (burst_q.size() != 0 && !gap) begin
                    ddr_rvalid <= 1'b1;
                    ddr_rdata  <= line_pattern(burst_q[0] + ddr_line_t'(beat_idx));
                    ddr_rlast  <= (beat_idx == BURST_BEATS - 1);
                end else begin
                    ddr_rvalid <= 1'b0;
                    ddr_rlast  <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (reset_n && fetch_done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ==============================
    // Test steps
    // ==============================
    task automatic end_test(input string name);
        int errs;
        errs = total_errors() - err_mark;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "pass" : "fail", errs);
        err_mark = total_errors();
    endtask

    // Optional second edge mid-fetch carries another block and target
    task automatic run_fetch(input ddr_line_t base, input target_e tgt, input logic heavy,
                             input logic retrigger);
        int start_cnt;
        start_cnt = done_cnt;
        @(posedge clk);
        stall_heavy  <= heavy;
        fetch_addr   <= base;
        fetch_target <= tgt;
        fetch_en     <= 1'b1;
        if (retrigger) begin
            repeat (60) @(posedge clk);
            fetch_en <= 1'b0;
            @(posedge clk);
            fetch_en     <= 1'b1;
            fetch_addr   <= base + 26'h40;
            fetch_target <= (tgt == TGT_LEFT) ? TGT_RIGHT : TGT_LEFT;
        end
        while (done_cnt == start_cnt) @(posedge clk);
        fetch_en <= 1'b0;
        // Window for a stray second pulse
        repeat (20) @(posedge clk);
        assert (done_cnt - start_cnt == 1) else begin
            $display("CHECK FAILED o_fetch_done pulses: got %h expected %h",
                     done_cnt - start_cnt, 1);
            check_errs++;
        end
    endtask

    // Address out after edge m, registered at m+1, sampled at m+2
    task automatic mantissa_readback(input target_e tgt, input ddr_line_t base);
        line_t got;
        line_t expected;
        string sig;
        sig = (tgt == TGT_LEFT) ? "o_man_rd_data_left" : "o_man_rd_data_right";
        for (int m = 0; m < MAN_LINES + 2; m++) begin
            @(posedge clk);
            if (m >= 2) begin
                got      = (tgt == TGT_LEFT) ? man_rd_data_left : man_rd_data_right;
                expected = line_pattern(base + ddr_line_t'(EXP_LINES + m - 2));
                assert (got == expected) else begin
                    $display("CHECK FAILED %s[%0d]: got %h expected %h",
                             sig, m - 2, got, expected);
                    check_errs++;
                end
            end
            if (tgt == TGT_LEFT) begin
                man_rd_en_left   <= (m < MAN_LINES);
                man_rd_addr_left <= man_idx_t'(m);
            end else begin
                man_rd_en_right   <= (m < MAN_LINES);
                man_rd_addr_right <= man_idx_t'(m);
            end
        end
    endtask

    // Combinational port, sampled one edge after the address
    task automatic exponent_readback(input target_e tgt, input ddr_line_t base);
        exp_t  got;
        exp_t  expected;
        string sig;
        sig = (tgt == TGT_LEFT) ? "o_exp_rd_data_left" : "o_exp_rd_data_right";
        for (int n = 0; n < EXP_COUNT + 1; n++) begin
            @(posedge clk);
            if (n >= 1) begin
                got      = (tgt == TGT_LEFT) ? exp_rd_data_left : exp_rd_data_right;
                expected = aligned_exp(base, n - 1);
                assert (got == expected) else begin
                    $display("CHECK FAILED %s[%0d]: got %h expected %h",
                             sig, n - 1, got, expected);
                    check_errs++;
                end
            end
            if (tgt == TGT_LEFT) begin
                exp_rd_addr_left <= exp_idx_t'(n);
            end else begin
                exp_rd_addr_right <= exp_idx_t'(n);
            end
        end
    endtask

    initial begin
        @(posedge clk);
        while (!reset_n) @(posedge clk);
        repeat (10) @(posedge clk);
        end_test("idle outputs after reset");

        run_fetch(26'h100, TGT_LEFT, 1'b0, 1'b0);
        mantissa_readback(TGT_LEFT, 26'h100);
        end_test("left fetch, burst addresses and mantissas");

        exponent_readback(TGT_LEFT, 26'h100);
        end_test("left aligned exponents");

        // Right block under heavy stalls, left block must survive it
        run_fetch(26'h2A0, TGT_RIGHT, 1'b1, 1'b0);
        mantissa_readback(TGT_RIGHT, 26'h2A0);
        exponent_readback(TGT_RIGHT, 26'h2A0);
        mantissa_readback(TGT_LEFT, 26'h100);
        exponent_readback(TGT_LEFT, 26'h100);
        end_test("stalled right fetch, left unchanged");

        run_fetch(26'h100, TGT_LEFT, 1'b0, 1'b1);
        end_test("command edge during fetch ignored");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
// ==============================
// Testbench clock and synchronous active-low reset
// ==============================
module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_reset_n
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Released on a rising edge, like every other DUT input
    initial begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset_n <= 1'b1;
    end

endmodule
